// File: src/axi_lite_selftest_macros.svh
`ifndef AXI_LITE_SELFTEST_MACROS_SVH
`define AXI_LITE_SELFTEST_MACROS_SVH

// ---------------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------------
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// ---------------------------------------------------------------------------
// run shape
// ---------------------------------------------------------------------------
`define TXN_NUM 4 // writes per run, same number of reads

`define SLAVE_BASE 32'h4000_0000 // offset 0 maps here
`define START_DATA 32'hAA00_0000 // value of word 0

// protection codes, data access
`define AWPROT_CODE 3'b000
`define ARPROT_CODE 3'b001 // privileged read

`endif

// File: src/axi_lite_selftest_pkg.sv
`include "axi_lite_selftest_macros.svh"

package axi_lite_selftest_pkg;

	// ---------------------------------------------------------------------------
	// bus vectors
	// ---------------------------------------------------------------------------
	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [`AXI_DATA_W-1:0] data_t;
	typedef logic [`AXI_DATA_W/8-1:0] strb_t; // one bit per byte lane
	typedef logic [2:0] prot_t;
	typedef logic [1:0] resp_t; // bit 1 set means SLVERR or DECERR

	// counts 0 up to and including TXN_NUM
	typedef logic [$clog2(`TXN_NUM+1)-1:0] txn_idx_t;

	// ---------------------------------------------------------------------------
	// run sequencer FSM
	// ---------------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		seq_idle,    // waiting for a start edge
		seq_write,   // issuing writes one by one
		seq_read,    // issuing reads one by one
		seq_compare  // latch result, raise done
	} seq_state_t;

endpackage

// File: src/txn_sequencer.sv
`timescale 1ns/10ps

module txn_sequencer
(
	input  logic M_AXI_ACLK,
	input  logic M_AXI_ARESETN,
	input  logic init_axi_txn,
	input  logic write_idle,
	input  logic writes_done,
	input  logic write_err,
	input  logic read_idle,
	input  logic reads_done,
	input  logic read_err,
	output logic run_clear,   // clears both channels for a new run
	output logic issue_write,
	output logic issue_read,
	output logic txn_done,
	output logic error
);

	import axi_lite_selftest_pkg::*;

	seq_state_t state;
	logic       init_ff;
	logic       init_ff2;
	logic       start_pulse;

	// ---------------------------------------------------------------------------
	// start edge
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			init_ff  <= 1'b0;
			init_ff2 <= 1'b0;
		end
		else
		begin
			init_ff  <= init_axi_txn;
			init_ff2 <= init_ff;
		end
	end

	assign start_pulse = init_ff && !init_ff2;
	// a start edge mid-run is ignored
	assign run_clear   = start_pulse && (state == seq_idle);

	// ---------------------------------------------------------------------------
	// run FSM
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			state       <= seq_idle;
			issue_write <= 1'b0;
			issue_read  <= 1'b0;
			txn_done    <= 1'b0;
			error       <= 1'b0;
		end
		else
		begin
			issue_write <= 1'b0; // issue lines are single-cycle
			issue_read  <= 1'b0;
			case (state)
				seq_idle:
				begin
					if (run_clear)
					begin
						state    <= seq_write;
						txn_done <= 1'b0;
						error    <= 1'b0;
					end
				end
				seq_write:
				begin
					if (writes_done)
						state <= seq_read;
					else if (write_idle && !issue_write)
						issue_write <= 1'b1; // next write once the last B is back
				end
				seq_read:
				begin
					if (reads_done)
						state <= seq_compare;
					else if (read_idle && !issue_read)
						issue_read <= 1'b1;
				end
				seq_compare:
				begin
					error    <= write_err || read_err;
					txn_done <= 1'b1;
					state    <= seq_idle;
				end
				default:
					state <= seq_idle;
			endcase
		end
	end

	// one transaction kind in flight, writes only while in the write phase
	a_issue_excl: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		!(issue_write && issue_read));
	a_issue_write_phase: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		issue_write |-> state == seq_write);

endmodule

// File: src/axi_write_channel.sv
`timescale 1ns/10ps

`include "axi_lite_selftest_macros.svh"

module axi_write_channel
(
	input  logic                          M_AXI_ACLK,
	input  logic                          M_AXI_ARESETN,
	input  logic                          run_clear,
	input  logic                          issue_write,
	input  logic                          awready,
	input  logic                          wready,
	input  logic                          bvalid,
	input  axi_lite_selftest_pkg::resp_t bresp,
	output axi_lite_selftest_pkg::addr_t awaddr,
	output logic                          awvalid,
	output axi_lite_selftest_pkg::data_t wdata,
	output logic                          wvalid,
	output logic                          bready,
	output logic                          write_idle,
	output logic                          writes_done,
	output logic                          write_err
);

	import axi_lite_selftest_pkg::*;

	addr_t    aw_off; // byte offset from the slave base
	txn_idx_t w_idx;  // words accepted on W
	txn_idx_t b_cnt;  // responses accepted on B
	logic     busy;
	logic     aw_hs;
	logic     w_hs;
	logic     b_hs;

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;
	assign b_hs  = bvalid && bready;

	assign awaddr = addr_t'(`SLAVE_BASE) + aw_off;
	assign wdata  = data_t'(`START_DATA) + data_t'(w_idx);

	// ---------------------------------------------------------------------------
	// AW and W valids, raised together
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
		begin
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end
		else if (issue_write)
		begin
			awvalid <= 1'b1;
			wvalid  <= 1'b1;
		end
		else
		begin
			if (aw_hs)
				awvalid <= 1'b0;
			if (w_hs)
				wvalid <= 1'b0; // each drops on its own ready
		end
	end

	// address and data advance after their handshakes
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
		begin
			aw_off <= '0;
			w_idx  <= '0;
		end
		else
		begin
			if (aw_hs)
				aw_off <= aw_off + addr_t'(4);
			if (w_hs)
				w_idx <= w_idx + 1'b1;
		end
	end

	// ---------------------------------------------------------------------------
	// B channel
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
			bready <= 1'b0;
		else
			bready <= bvalid && !bready; // one-cycle pulse after bvalid
	end

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
		begin
			busy      <= 1'b0;
			b_cnt     <= '0;
			write_err <= 1'b0;
		end
		else
		begin
			if (issue_write)
				busy <= 1'b1;
			else if (b_hs)
				busy <= 1'b0; // transaction ends with its response
			if (b_hs)
			begin
				b_cnt <= b_cnt + 1'b1;
				if (bresp[1])
					write_err <= 1'b1;
			end
		end
	end

	assign write_idle  = !busy;
	assign writes_done = (b_cnt == txn_idx_t'(`TXN_NUM));

	a_awvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		awvalid && !awready |=> awvalid);
	a_wdata_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		wvalid && !wready |=> $stable(wdata));

endmodule

// File: src/axi_read_channel.sv
`timescale 1ns/10ps

`include "axi_lite_selftest_macros.svh"

module axi_read_channel
(
	input  logic                          M_AXI_ACLK,
	input  logic                          M_AXI_ARESETN,
	input  logic                          run_clear,
	input  logic                          issue_read,
	input  logic                          arready,
	input  logic                          rvalid,
	input  axi_lite_selftest_pkg::data_t rdata,
	input  axi_lite_selftest_pkg::resp_t rresp,
	output axi_lite_selftest_pkg::addr_t araddr,
	output logic                          arvalid,
	output logic                          rready,
	output logic                          read_idle,
	output logic                          reads_done,
	output logic                          read_err
);

	import axi_lite_selftest_pkg::*;

	addr_t    ar_off;
	txn_idx_t r_cnt;    // R handshakes so far, also the word index
	data_t    exp_data; // word the current read should return
	logic     busy;
	logic     ar_hs;
	logic     r_hs;
	logic     mismatch;

	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready;

	assign araddr   = addr_t'(`SLAVE_BASE) + ar_off;
	assign exp_data = data_t'(`START_DATA) + data_t'(r_cnt);
	assign mismatch = (rdata != exp_data);

	// ---------------------------------------------------------------------------
	// AR channel
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
			arvalid <= 1'b0;
		else if (issue_read)
			arvalid <= 1'b1;
		else if (ar_hs)
			arvalid <= 1'b0;
	end

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
			ar_off <= '0;
		else if (ar_hs)
			ar_off <= ar_off + addr_t'(4); // next word
	end

	// ---------------------------------------------------------------------------
	// R channel and checking
	// ---------------------------------------------------------------------------
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
			rready <= 1'b0;
		else
			rready <= rvalid && !rready;
	end

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN || run_clear)
		begin
			busy     <= 1'b0;
			r_cnt    <= '0;
			read_err <= 1'b0;
		end
		else
		begin
			if (issue_read)
				busy <= 1'b1;
			else if (r_hs)
				busy <= 1'b0;
			if (r_hs)
			begin
				r_cnt <= r_cnt + 1'b1;
				// bad data or error response, either one fails the run
				if (mismatch || rresp[1])
					read_err <= 1'b1;
			end
		end
	end

	assign read_idle  = !busy;
	assign reads_done = (r_cnt == txn_idx_t'(`TXN_NUM));

	a_arvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		arvalid && !arready |=> arvalid);

endmodule

// File: src/axi_lite_selftest.sv
`timescale 1ns/10ps

`include "axi_lite_selftest_macros.svh"

module axi_lite_selftest
(
	input  logic                          M_AXI_ACLK,
	input  logic                          M_AXI_ARESETN,
	input  logic                          init_axi_txn, // rising edge starts a run
	output logic                          txn_done,
	output logic                          error,
	// write address
	output axi_lite_selftest_pkg::addr_t m_axi_awaddr,
	output axi_lite_selftest_pkg::prot_t m_axi_awprot,
	output logic                          m_axi_awvalid,
	input  logic                          m_axi_awready,
	// write data
	output axi_lite_selftest_pkg::data_t m_axi_wdata,
	output axi_lite_selftest_pkg::strb_t m_axi_wstrb,
	output logic                          m_axi_wvalid,
	input  logic                          m_axi_wready,
	// write response
	input  logic                          m_axi_bvalid,
	input  axi_lite_selftest_pkg::resp_t m_axi_bresp,
	output logic                          m_axi_bready,
	// read address
	output axi_lite_selftest_pkg::addr_t m_axi_araddr,
	output axi_lite_selftest_pkg::prot_t m_axi_arprot,
	output logic                          m_axi_arvalid,
	input  logic                          m_axi_arready,
	// read data
	input  logic                          m_axi_rvalid,
	input  axi_lite_selftest_pkg::data_t m_axi_rdata,
	input  axi_lite_selftest_pkg::resp_t m_axi_rresp,
	output logic                          m_axi_rready
);

	import axi_lite_selftest_pkg::*;

	logic run_clear;
	logic issue_write;
	logic issue_read;
	logic write_idle;
	logic writes_done;
	logic write_err;
	logic read_idle;
	logic reads_done;
	logic read_err;

	// fixed sideband, all lanes written every time
	assign m_axi_awprot = prot_t'(`AWPROT_CODE);
	assign m_axi_arprot = prot_t'(`ARPROT_CODE);
	assign m_axi_wstrb  = '1;

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------
	txn_sequencer u_seq
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.init_axi_txn  (init_axi_txn),
		.write_idle    (write_idle),
		.writes_done   (writes_done),
		.write_err     (write_err),
		.read_idle     (read_idle),
		.reads_done    (reads_done),
		.read_err      (read_err),
		.run_clear     (run_clear),
		.issue_write   (issue_write),
		.issue_read    (issue_read),
		.txn_done      (txn_done),
		.error         (error)
	);

	axi_write_channel u_wr
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.run_clear     (run_clear),
		.issue_write   (issue_write),
		.awready       (m_axi_awready),
		.wready        (m_axi_wready),
		.bvalid        (m_axi_bvalid),
		.bresp         (m_axi_bresp),
		.awaddr        (m_axi_awaddr),
		.awvalid       (m_axi_awvalid),
		.wdata         (m_axi_wdata),
		.wvalid        (m_axi_wvalid),
		.bready        (m_axi_bready),
		.write_idle    (write_idle),
		.writes_done   (writes_done),
		.write_err     (write_err)
	);

	axi_read_channel u_rd
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.run_clear     (run_clear),
		.issue_read    (issue_read),
		.arready       (m_axi_arready),
		.rvalid        (m_axi_rvalid),
		.rdata         (m_axi_rdata),
		.rresp         (m_axi_rresp),
		.araddr        (m_axi_araddr),
		.arvalid       (m_axi_arvalid),
		.rready        (m_axi_rready),
		.read_idle     (read_idle),
		.reads_done    (reads_done),
		.read_err      (read_err)
	);

endmodule

// File: bench/axi_lite_mem_model.sv
`timescale 1ns/10ps

`include "axi_lite_selftest_macros.svh"

module axi_lite_mem_model
(
	input  logic                         M_AXI_ACLK,
	input  logic                         M_AXI_ARESETN,
	input  logic [7:0]                   wr_err_idx, // word answered with SLVERR
	input  logic [7:0]                   rd_bad_idx, // word returned inverted
	input  axi_lite_selftest_pkg::addr_t awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  axi_lite_selftest_pkg::data_t wdata,
	input  logic                         wvalid,
	output logic                         wready,
	output logic                         bvalid,
	output axi_lite_selftest_pkg::resp_t bresp,
	input  logic                         bready,
	input  axi_lite_selftest_pkg::addr_t araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic                         rvalid,
	output axi_lite_selftest_pkg::data_t rdata,
	output axi_lite_selftest_pkg::resp_t rresp,
	input  logic                         rready
);

	import axi_lite_selftest_pkg::*;

	data_t      mem [16];
	logic [7:0] lfsr;
	logic [7:0] aw_idx;
	logic [7:0] ar_idx;
	data_t      w_word;
	logic       aw_hs;
	logic       w_hs;
	logic       b_hs;
	logic       ar_hs;
	logic       r_hs;
	logic       have_aw;
	logic       have_w;
	logic       have_ar;
	logic [1:0] aw_wait;
	logic [1:0] w_wait;
	logic [1:0] b_wait;
	logic [1:0] ar_wait;
	logic [1:0] r_wait;

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// one LFSR step per delay bit
	task automatic draw_delay(output logic [1:0] d);
		lfsr = lfsr_next(lfsr);
		d[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		d[1] = lfsr[0];
	endtask

	function automatic logic [7:0] word_index(input addr_t a);
		addr_t off;
		off = a - addr_t'(`SLAVE_BASE);
		return off[9:2];
	endfunction

	// ---------------------------------------------------------------------------
	// handshakes as seen on the rising edge
	// ---------------------------------------------------------------------------
	always @(posedge M_AXI_ACLK)
	begin
		aw_hs <= M_AXI_ARESETN && awvalid && awready;
		w_hs  <= M_AXI_ARESETN && wvalid && wready;
		b_hs  <= M_AXI_ARESETN && bvalid && bready;
		ar_hs <= M_AXI_ARESETN && arvalid && arready;
		r_hs  <= M_AXI_ARESETN && rvalid && rready;
		if (awvalid && awready)
			aw_idx <= word_index(awaddr);
		if (wvalid && wready)
			w_word <= wdata;
		if (arvalid && arready)
			ar_idx <= word_index(araddr);
	end

	// ---------------------------------------------------------------------------
	// slave outputs, all driven on the falling edge
	// ---------------------------------------------------------------------------
	always @(negedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= '0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= '0;
			have_aw = 1'b0;
			have_w  = 1'b0;
			have_ar = 1'b0;
			aw_wait = '0;
			w_wait  = '0;
			b_wait  = '0;
			ar_wait = '0;
			r_wait  = '0;
			lfsr    = 8'd39;
			for (int i = 0; i < 16; i++)
				mem[i] = ~(addr_t'(`SLAVE_BASE) + addr_t'(4 * i)); // inverted address
		end
		else
		begin
			if (aw_hs)
			begin
				awready <= 1'b0;
				have_aw = 1'b1;
				draw_delay(aw_wait);
			end
			else if (awvalid && !awready && !have_aw)
			begin
				if (aw_wait == 0)
					awready <= 1'b1;
				else
					aw_wait = aw_wait - 1'b1;
			end

			if (w_hs)
			begin
				wready <= 1'b0;
				have_w = 1'b1;
				draw_delay(w_wait);
			end
			else if (wvalid && !wready && !have_w)
			begin
				if (w_wait == 0)
					wready <= 1'b1;
				else
					w_wait = w_wait - 1'b1;
			end

			// write response once both address and data are in
			if (b_hs)
				bvalid <= 1'b0;
			else if (have_aw && have_w && !bvalid)
			begin
				if (b_wait == 0)
				begin
					if (aw_idx == wr_err_idx)
						bresp <= 2'b10; // SLVERR, word left unchanged
					else
					begin
						bresp <= 2'b00;
						mem[aw_idx[3:0]] = w_word;
					end
					bvalid <= 1'b1;
					have_aw = 1'b0;
					have_w  = 1'b0;
					draw_delay(b_wait);
				end
				else
					b_wait = b_wait - 1'b1;
			end

			if (ar_hs)
			begin
				arready <= 1'b0;
				have_ar = 1'b1;
				draw_delay(ar_wait);
			end
			else if (arvalid && !arready && !have_ar)
			begin
				if (ar_wait == 0)
					arready <= 1'b1;
				else
					ar_wait = ar_wait - 1'b1;
			end

			if (r_hs)
				rvalid <= 1'b0;
			else if (have_ar && !rvalid)
			begin
				if (r_wait == 0)
				begin
					if (ar_idx == rd_bad_idx)
						rdata <= ~mem[ar_idx[3:0]]; // corrupted word
					else
						rdata <= mem[ar_idx[3:0]];
					rresp  <= 2'b00;
					rvalid <= 1'b1;
					have_ar = 1'b0;
					draw_delay(r_wait);
				end
				else
					r_wait = r_wait - 1'b1;
			end
		end
	end

endmodule

// File: bench/tb_axi_lite_selftest.sv
`timescale 1ns/10ps

`include "axi_lite_selftest_macros.svh"

module tb_axi_lite_selftest;

	import axi_lite_selftest_pkg::*;

	localparam int         CLK_PERIOD  = 4;
	localparam int         WATCHDOG_NS = 3 * `TXN_NUM * 2 * 20 * CLK_PERIOD;
	localparam logic [7:0] NO_WORD     = 8'hFF; // no error injection

	logic       M_AXI_ACLK;
	logic       M_AXI_ARESETN;
	logic       init_axi_txn;
	logic [7:0] wr_err_idx;
	logic [7:0] rd_bad_idx;
	logic       txn_done;
	logic       error;
	addr_t      awaddr;
	logic [2:0] awprot;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	logic [`AXI_DATA_W/8-1:0] wstrb;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	resp_t      bresp;
	logic       bready;
	addr_t      araddr;
	logic [2:0] arprot;
	logic       arvalid;
	logic       arready;
	logic       rvalid;
	data_t      rdata;
	resp_t      rresp;
	logic       rready;

	// scoreboard state, owned by the checker block
	int    aw_cnt;
	int    w_cnt;
	int    b_cnt;
	int    ar_cnt;
	int    r_cnt;
	int    runs_done;
	logic  exp_error;
	logic  started;
	logic  prev_init;
	logic  prev_awvalid;
	logic  prev_awready;
	logic  prev_wvalid;
	logic  prev_wready;
	logic  prev_arvalid;
	logic  prev_arready;
	logic  prev_bvalid;
	logic  prev_bready;
	logic  prev_rvalid;
	logic  prev_rready;
	logic  prev_txn_done;
	addr_t prev_awaddr;
	data_t prev_wdata;
	addr_t prev_araddr;

	axi_lite_selftest u_dut
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.init_axi_txn  (init_axi_txn),
		.txn_done      (txn_done),
		.error         (error),
		.m_axi_awaddr  (awaddr),
		.m_axi_awprot  (awprot),
		.m_axi_awvalid (awvalid),
		.m_axi_awready (awready),
		.m_axi_wdata   (wdata),
		.m_axi_wstrb   (wstrb),
		.m_axi_wvalid  (wvalid),
		.m_axi_wready  (wready),
		.m_axi_bvalid  (bvalid),
		.m_axi_bresp   (bresp),
		.m_axi_bready  (bready),
		.m_axi_araddr  (araddr),
		.m_axi_arprot  (arprot),
		.m_axi_arvalid (arvalid),
		.m_axi_arready (arready),
		.m_axi_rvalid  (rvalid),
		.m_axi_rdata   (rdata),
		.m_axi_rresp   (rresp),
		.m_axi_rready  (rready)
	);

	axi_lite_mem_model u_mem
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.wr_err_idx    (wr_err_idx),
		.rd_bad_idx    (rd_bad_idx),
		.awaddr        (awaddr),
		.awvalid       (awvalid),
		.awready       (awready),
		.wdata         (wdata),
		.wvalid        (wvalid),
		.wready        (wready),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.bready        (bready),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.rvalid        (rvalid),
		.rdata         (rdata),
		.rresp         (rresp),
		.rready        (rready)
	);

	always #(CLK_PERIOD / 2) M_AXI_ACLK = ~M_AXI_ACLK;

	// ---------------------------------------------------------------------------
	// failure reporting
	// ---------------------------------------------------------------------------
	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic fail_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
		stop_on_failure();
	endtask

	task automatic fail_event(input string what);
		$display("%0d ns: %s", $time, what);
		stop_on_failure();
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else fail_value(name, exp, act);
	endtask

	// ---------------------------------------------------------------------------
	// protocol and result checker, samples on the rising edge
	// ---------------------------------------------------------------------------
	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			started       = 1'b0;
			prev_init     = 1'b0;
			prev_awvalid  = 1'b0;
			prev_awready  = 1'b0;
			prev_wvalid   = 1'b0;
			prev_wready   = 1'b0;
			prev_arvalid  = 1'b0;
			prev_arready  = 1'b0;
			prev_bvalid   = 1'b0;
			prev_bready   = 1'b0;
			prev_rvalid   = 1'b0;
			prev_rready   = 1'b0;
			prev_txn_done = 1'b0;
		end
		else
		begin
			if (!started)
			begin
				// quiet bus until the first start edge
				check_eq("awvalid", 0, awvalid);
				check_eq("wvalid", 0, wvalid);
				check_eq("arvalid", 0, arvalid);
				check_eq("bready", 0, bready);
				check_eq("rready", 0, rready);
				check_eq("txn_done", 0, txn_done);
				check_eq("error", 0, error);
			end
			if (init_axi_txn && !prev_init)
			begin
				started = 1'b1;
				aw_cnt  = 0;
				w_cnt   = 0;
				b_cnt   = 0;
				ar_cnt  = 0;
				r_cnt   = 0;
			end

			// held valids keep their payload
			if (prev_awvalid && !prev_awready)
			begin
				check_eq("awvalid", 1, awvalid);
				check_eq("awaddr", prev_awaddr, awaddr);
			end
			if (prev_wvalid && !prev_wready)
			begin
				check_eq("wvalid", 1, wvalid);
				check_eq("wdata", prev_wdata, wdata);
			end
			if (prev_arvalid && !prev_arready)
			begin
				check_eq("arvalid", 1, arvalid);
				check_eq("araddr", prev_araddr, araddr);
			end

			if (awvalid && !prev_awvalid)
			begin
				check_eq("wvalid", 1, wvalid); // AW and W rise together
				check_eq("txn_done", 0, txn_done);
				check_eq("B handshakes at awvalid", aw_cnt, b_cnt);
			end
			if (arvalid && !prev_arvalid)
			begin
				check_eq("txn_done", 0, txn_done);
				check_eq("B handshakes at arvalid", `TXN_NUM, b_cnt);
				check_eq("R handshakes at arvalid", ar_cnt, r_cnt);
			end

			// single-cycle ready pulses after a valid
			if (bready)
			begin
				check_eq("bvalid", 1, bvalid);
				check_eq("bvalid one cycle earlier", 1, prev_bvalid);
				check_eq("bready one cycle earlier", 0, prev_bready);
			end
			if (rready)
			begin
				check_eq("rvalid", 1, rvalid);
				check_eq("rvalid one cycle earlier", 1, prev_rvalid);
				check_eq("rready one cycle earlier", 0, prev_rready);
			end

			if (awvalid && awready)
			begin
				assert (aw_cnt < `TXN_NUM) else fail_event("extra AW handshake in one run");
				check_eq("awaddr", `SLAVE_BASE + 4 * aw_cnt, awaddr);
				check_eq("awprot", `AWPROT_CODE, awprot);
				aw_cnt++;
			end
			if (wvalid && wready)
			begin
				check_eq("wdata", `START_DATA + w_cnt, wdata);
				check_eq("wstrb", {(`AXI_DATA_W/8){1'b1}}, wstrb);
				w_cnt++;
			end
			if (bvalid && bready)
				b_cnt++;
			if (arvalid && arready)
			begin
				assert (ar_cnt < `TXN_NUM) else fail_event("extra AR handshake in one run");
				check_eq("araddr", `SLAVE_BASE + 4 * ar_cnt, araddr);
				check_eq("arprot", `ARPROT_CODE, arprot);
				ar_cnt++;
			end
			if (rvalid && rready)
				r_cnt++;

			// end of run
			if (txn_done && !prev_txn_done)
			begin
				check_eq("AW handshake count", `TXN_NUM, aw_cnt);
				check_eq("W handshake count", `TXN_NUM, w_cnt);
				check_eq("B handshake count", `TXN_NUM, b_cnt);
				check_eq("AR handshake count", `TXN_NUM, ar_cnt);
				check_eq("R handshake count", `TXN_NUM, r_cnt);
				check_eq("error", exp_error, error);
				runs_done++;
			end

			prev_init     = init_axi_txn;
			prev_awvalid  = awvalid;
			prev_awready  = awready;
			prev_wvalid   = wvalid;
			prev_wready   = wready;
			prev_arvalid  = arvalid;
			prev_arready  = arready;
			prev_bvalid   = bvalid;
			prev_bready   = bready;
			prev_rvalid   = rvalid;
			prev_rready   = rready;
			prev_txn_done = txn_done;
			prev_awaddr   = awaddr;
			prev_wdata    = wdata;
			prev_araddr   = araddr;
		end
	end

	// ---------------------------------------------------------------------------
	// stimulus, driven on the falling edge
	// ---------------------------------------------------------------------------
	task automatic run_once(input logic [7:0] bad_write, input logic [7:0] bad_read,
		input logic want_error);
		int runs_before;
		runs_before  = runs_done;
		wr_err_idx   = bad_write;
		rd_bad_idx   = bad_read;
		exp_error    = want_error;
		init_axi_txn = 1'b1;
		while (runs_done == runs_before)
			@(negedge M_AXI_ACLK);
		init_axi_txn = 1'b0;
		repeat (3) @(negedge M_AXI_ACLK); // init low long enough for a fresh edge
	endtask

	initial
	begin
		M_AXI_ACLK    = 1'b0;
		M_AXI_ARESETN = 1'b0;
		init_axi_txn  = 1'b0;
		wr_err_idx    = NO_WORD;
		rd_bad_idx    = NO_WORD;
		exp_error     = 1'b0;
		runs_done     = 0;
		repeat (2) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
		repeat (4) @(negedge M_AXI_ACLK);

		run_once(NO_WORD, NO_WORD, 1'b0); // clean
		run_once(8'd2, NO_WORD, 1'b1);    // SLVERR on word 2
		run_once(NO_WORD, 8'd1, 1'b1);    // word 1 read back inverted

		$display("TEST OK");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		fail_event("watchdog expired before all three runs finished");
	end

endmodule

// File: axi_lite_selftest.f
+incdir+src
src/axi_lite_selftest_pkg.sv
src/txn_sequencer.sv
src/axi_write_channel.sv
src/axi_read_channel.sv
src/axi_lite_selftest.sv
bench/axi_lite_mem_model.sv
bench/tb_axi_lite_selftest.sv

// File: Makefile
# Verilator build and run of the self-testing AXI4-Lite master

VERILATOR ?= verilator
TOP       ?= tb_axi_lite_selftest
# set to --trace to build with trace support
TRACE     ?=

FLIST   := axi_lite_selftest.f
OBJ_DIR := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal $(TRACE) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
